//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fpv
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+sim
hw/fpv_pkg.sv
hw/word_ram.sv
hw/fmul.sv
hw/apb_regs.sv
hw/idx_counter.sv
hw/vec_seq.sv
hw/fpv_top.sv
sim/tb_fpv.sv

//--- hw/apb_regs.sv
`timescale 1ns/1ns

module apb_regs import fpv_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [addr_w-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  input  logic              busy,
  input  logic              done,
  input  logic [31:0]       res_rdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              a_we,
  output logic              b_we,
  output logic [idx_w-1:0]  wr_idx,
  output logic [31:0]       wdata,
  output logic [idx_w-1:0]  res_raddr,
  output logic [len_w-1:0]  len,
  output logic              start
);

  logic acc_wr;
  logic acc_rd;
  logic sel_ctrl;
  logic sel_status;
  logic sel_len;
  logic sel_a;
  logic sel_b;
  logic sel_r;
  logic wr_err;
  logic wr_ok;
  logic rd_pend;

  function automatic logic win_hit(input logic [addr_w-1:0] a, input logic [addr_w-1:0] base);
    return a[addr_w-1:idx_w+2] == base[addr_w-1:idx_w+2];
  endfunction

  assign acc_wr = psel && penable && pwrite;
  assign acc_rd = psel && penable && !pwrite;

  assign sel_ctrl = paddr == addr_ctrl;
  assign sel_status = paddr == addr_status;
  assign sel_len = paddr == addr_len;
  assign sel_a = win_hit(paddr, win_a);
  assign sel_b = win_hit(paddr, win_b);
  assign sel_r = win_hit(paddr, win_r);

  // results are read only; oversize lengths rejected
  assign wr_err = acc_wr && (sel_r || (busy && (sel_a || sel_b || sel_len)) ||
                             (sel_len && pwdata > 32'(depth)));
  assign wr_ok = acc_wr && !wr_err;

  assign a_we = wr_ok && sel_a;
  assign b_we = wr_ok && sel_b;
  assign wr_idx = paddr[idx_w+1:2];
  assign wdata = pwdata;
  assign res_raddr = paddr[idx_w+1:2];

  assign start = acc_wr && sel_ctrl && pwdata[0] && !busy && len != '0;

  // first access cycle of a result read waits on the RAM
  assign pready = !(acc_rd && sel_r && !rd_pend);
  assign pslverr = wr_err;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_pend <= 1'b0;
      len <= '0;
    end else begin
      rd_pend <= acc_rd && sel_r && !rd_pend;
      if (wr_ok && sel_len) begin
        len <= pwdata[len_w-1:0];
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (sel_status) begin
      prdata[1:0] = {done, busy};
    end else if (sel_len) begin
      prdata[len_w-1:0] = len;
    end else if (sel_r) begin
      prdata = res_rdata;
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (!rstn) start |-> !busy ##1 busy);

endmodule

//--- hw/fmul.sv
`timescale 1ns/1ns

module fmul import fpv_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        order,
  input  logic [31:0] rs1,
  input  logic [31:0] rs2,
  output logic        accepted,
  output logic        done,
  output logic [31:0] rd
);

  fp32_t op_a;
  fp32_t op_b;
  fp32_t res;

  logic [8:0] ea;
  logic [8:0] eb;
  logic [8:0] esum;

  logic        v1;
  logic        sign_1;
  logic        zero_1;
  logic [23:0] ma_1;
  logic [23:0] mb_1;
  logic [7:0]  eyd_1;
  logic [8:0]  ufl_sh_1;
  logic        udf_1;
  logic        udf_just_1;

  logic        v2;
  logic        sign_2;
  logic        zero_2;
  logic [47:0] prod_2;
  logic [5:0]  lzc_2;
  logic [7:0]  eyd_2;
  logic [8:0]  ufl_sh_2;
  logic        udf_2;
  logic        udf_just_2;

  logic [47:0]       prod;
  logic [5:0]        lzc;
  logic signed [8:0] eyf;
  logic [47:0]       norm_prod;
  logic [47:0]       sub_prod;
  logic [47:0]       ufl_prod;

  // pipeline never stalls
  assign accepted = order;
  assign done = v2;

  assign op_a = rs1;
  assign op_b = rs2;

  // subnormal inputs count as exponent 1
  assign ea = (op_a.f.exp == 8'd0) ? 9'd1 : {1'b0, op_a.f.exp};
  assign eb = (op_b.f.exp == 8'd0) ? 9'd1 : {1'b0, op_b.f.exp};
  assign esum = ea + eb;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= accepted;
      v2 <= v1;
    end
  end

  always_ff @(posedge clk) begin
    sign_1 <= op_a.f.sign ^ op_b.f.sign;
    zero_1 <= (op_a.f.exp == 8'd0 && op_a.f.man == 23'd0) ||
              (op_b.f.exp == 8'd0 && op_b.f.man == 23'd0);
    ma_1 <= {op_a.f.exp != 8'd0, op_a.f.man};
    mb_1 <= {op_b.f.exp != 8'd0, op_b.f.man};
    // product msb sits at bit 47, so bias is 126
    eyd_1 <= esum[7:0] + 8'd130;
    ufl_sh_1 <= 9'd127 - esum;
    udf_1 <= esum < 9'd128;
    udf_just_1 <= esum == 9'd127;
  end

  assign prod = ma_1 * mb_1;

  always_comb begin
    lzc = 6'd48;
    for (int i = 0; i < 48; i++) begin
      if (prod[i]) begin
        lzc = 6'(47 - i);
      end
    end
  end

  always_ff @(posedge clk) begin
    sign_2 <= sign_1;
    zero_2 <= zero_1;
    prod_2 <= prod;
    lzc_2 <= lzc;
    eyd_2 <= eyd_1;
    ufl_sh_2 <= ufl_sh_1;
    udf_2 <= udf_1;
    udf_just_2 <= udf_just_1;
  end

  assign eyf = $signed({1'b0, eyd_2}) - $signed({3'b0, lzc_2});
  assign norm_prod = prod_2 << lzc_2;
  // exponent ran out before the leading one
  assign sub_prod = prod_2 << ({1'b0, eyd_2[4:0]} - 6'd1);
  assign ufl_prod = prod_2 >> ufl_sh_2;

  always_comb begin
    res.f.sign = sign_2;
    if (zero_2) begin
      res.f.exp = 8'd0;
      res.f.man = 23'd0;
    end else if (udf_2) begin
      // may just reach the minimum normal
      res.f.exp = (udf_just_2 && prod_2[47]) ? 8'd1 : 8'd0;
      res.f.man = ufl_prod[46:24];
    end else if (eyf > 9'sd0) begin
      res.f.exp = eyf[7:0];
      res.f.man = norm_prod[46:24];
    end else begin
      res.f.exp = 8'd0;
      res.f.man = sub_prod[46:24];
    end
  end

  assign rd = res.raw;

  // leading one lands on the hidden bit after normalization
  a_norm_msb: assert property (@(posedge clk) disable iff (!rstn)
    done && !zero_2 && !udf_2 && eyf > 9'sd0 |-> norm_prod[47]);

endmodule

//--- hw/fpv_pkg.sv
package fpv_pkg;

  localparam int depth = 16;
  localparam int idx_w = 4;
  localparam int len_w = 5;
  localparam int addr_w = 12;

  // register map
  localparam logic [addr_w-1:0] addr_ctrl = 12'h000;
  localparam logic [addr_w-1:0] addr_status = 12'h004;
  localparam logic [addr_w-1:0] addr_len = 12'h008;

  // window bases, one word per slot
  localparam logic [addr_w-1:0] win_a = 12'h100;
  localparam logic [addr_w-1:0] win_b = 12'h200;
  localparam logic [addr_w-1:0] win_r = 12'h300;

  // job states
  localparam logic [1:0] s_idle = 2'd0;
  localparam logic [1:0] s_issue = 2'd1;
  localparam logic [1:0] s_drain = 2'd2;
  localparam logic [1:0] s_fin = 2'd3;

  // single-precision word, raw or by field
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] man;
    } f;
  } fp32_t;

endpackage

//--- hw/fpv_top.sv
`timescale 1ns/1ns

module fpv_top import fpv_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [addr_w-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr
);

  logic             a_we;
  logic             b_we;
  logic [idx_w-1:0] wr_idx;
  logic [31:0]      wdata;
  logic [idx_w-1:0] res_raddr;
  logic [31:0]      res_rdata;
  logic [len_w-1:0] len;
  logic             start;
  logic             busy;
  logic             done;
  logic             clear;
  logic             issue_inc;
  logic             retire_inc;
  logic             issue_last;
  logic             retire_last;
  logic [idx_w-1:0] issue_idx;
  logic [idx_w-1:0] retire_idx;
  logic             order;
  logic             accepted;
  logic             mul_done;
  logic [31:0]      a_rdata;
  logic [31:0]      b_rdata;
  logic [31:0]      rd;

  apb_regs regs (
    .clk(clk), .rstn(rstn), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .busy(busy), .done(done), .res_rdata(res_rdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .a_we(a_we), .b_we(b_we),
    .wr_idx(wr_idx), .wdata(wdata), .res_raddr(res_raddr), .len(len), .start(start)
  );

  word_ram ram_a (
    .clk(clk), .we(a_we), .waddr(wr_idx), .wdata(wdata), .raddr(issue_idx), .rdata(a_rdata)
  );

  word_ram ram_b (
    .clk(clk), .we(b_we), .waddr(wr_idx), .wdata(wdata), .raddr(issue_idx), .rdata(b_rdata)
  );

  // results land at the retire slot
  word_ram ram_r (
    .clk(clk), .we(mul_done), .waddr(retire_idx), .wdata(rd), .raddr(res_raddr),
    .rdata(res_rdata)
  );

  idx_counter cnt (
    .clk(clk), .rstn(rstn), .clear(clear), .issue_inc(issue_inc), .retire_inc(retire_inc),
    .len(len), .issue_idx(issue_idx), .retire_idx(retire_idx), .issue_last(issue_last),
    .retire_last(retire_last)
  );

  vec_seq seq (
    .clk(clk), .rstn(rstn), .start(start), .issue_last(issue_last),
    .retire_last(retire_last), .accepted(accepted), .mul_done(mul_done), .order(order),
    .issue_inc(issue_inc), .retire_inc(retire_inc), .clear(clear), .busy(busy), .done(done)
  );

  fmul mul (
    .clk(clk), .rstn(rstn), .order(order), .rs1(a_rdata), .rs2(b_rdata),
    .accepted(accepted), .done(mul_done), .rd(rd)
  );

endmodule

//--- hw/idx_counter.sv
`timescale 1ns/1ns

module idx_counter import fpv_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  logic             clear,
  input  logic             issue_inc,
  input  logic             retire_inc,
  input  logic [len_w-1:0] len,
  output logic [idx_w-1:0] issue_idx,
  output logic [idx_w-1:0] retire_idx,
  output logic             issue_last,
  output logic             retire_last
);

  logic [len_w-1:0] len_m1;

  assign len_m1 = len - 1'b1;
  assign issue_last = len_w'(issue_idx) == len_m1;
  assign retire_last = len_w'(retire_idx) == len_m1;

  // both hold at the last slot
  always_ff @(posedge clk) begin
    if (!rstn) begin
      issue_idx <= '0;
      retire_idx <= '0;
    end else if (clear) begin
      issue_idx <= '0;
      retire_idx <= '0;
    end else begin
      if (issue_inc && !issue_last) begin
        issue_idx <= issue_idx + 1'b1;
      end
      if (retire_inc && !retire_last) begin
        retire_idx <= retire_idx + 1'b1;
      end
    end
  end

  a_order: assert property (@(posedge clk) disable iff (!rstn) retire_idx <= issue_idx);

endmodule

//--- hw/vec_seq.sv
`timescale 1ns/1ns

module vec_seq import fpv_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic start,
  input  logic issue_last,
  input  logic retire_last,
  input  logic accepted,
  input  logic mul_done,
  output logic order,
  output logic issue_inc,
  output logic retire_inc,
  output logic clear,
  output logic busy,
  output logic done
);

  logic [1:0] state;
  logic [1:0] inflight;

  assign clear = start;
  assign issue_inc = state == s_issue;
  assign retire_inc = mul_done;
  assign busy = state == s_issue || state == s_drain;
  assign done = state == s_fin;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= s_idle;
      order <= 1'b0;
      inflight <= 2'd0;
    end else begin
      // read address leads order by the RAM latency
      order <= state == s_issue;
      inflight <= inflight + {1'b0, accepted} - {1'b0, mul_done};
      case (state)
        s_idle, s_fin: begin
          if (start) begin
            state <= s_issue;
          end
        end
        s_issue: begin
          if (issue_last) begin
            state <= s_drain;
          end
        end
        s_drain: begin
          // last element retiring with nothing else in flight
          if (mul_done && retire_last && inflight == 2'd1) begin
            state <= s_fin;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

//--- hw/word_ram.sv
`timescale 1ns/1ns

module word_ram import fpv_pkg::*; (
  input  logic             clk,
  input  logic             we,
  input  logic [idx_w-1:0] waddr,
  input  logic [31:0]      wdata,
  input  logic [idx_w-1:0] raddr,
  output logic [31:0]      rdata
);

  logic [31:0] mem [depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, old data on collision
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

//--- sim/fmul_model.svh
`ifndef FMUL_MODEL_SVH
`define FMUL_MODEL_SVH

// exact significand product, truncated toward zero onto the fp32 grid
function automatic logic [31:0] fmul_model(input logic [31:0] a, input logic [31:0] b);
  fp32_t x;
  fp32_t y;
  fp32_t r;
  logic [47:0] sig;
  logic [47:0] frac;
  int          ex;
  int          msb;
  int          scale;
  x = a;
  y = b;
  r.raw = '0;
  r.f.sign = x.f.sign ^ y.f.sign;
  // value is sig times 2 to the ex, subnormals use exponent field 1 without hidden bit
  sig = 48'({x.f.exp != 8'd0, x.f.man}) * 48'({y.f.exp != 8'd0, y.f.man});
  ex = ((x.f.exp == 8'd0) ? 1 : int'(x.f.exp)) +
       ((y.f.exp == 8'd0) ? 1 : int'(y.f.exp)) - 300;
  if (sig == '0) begin
    return r.raw;
  end
  msb = 0;
  for (int i = 0; i < 48; i++) begin
    if (sig[i]) begin
      msb = i;
    end
  end
  if (msb + ex >= -126) begin
    // normal, keep 24 bits from the leading one
    r.f.exp = 8'(msb + ex + 127);
    scale = msb - 23;
  end else begin
    // subnormal grid step is 2^-149
    r.f.exp = 8'd0;
    scale = -149 - ex;
  end
  frac = (scale >= 0) ? (sig >> scale) : (sig << (-scale));
  r.f.man = frac[22:0];
  return r.raw;
endfunction

`endif

//--- sim/tb_fpv.sv
`timescale 1ns/1ns

module tb_fpv import fpv_pkg::*;;

  `include "fmul_model.svh"

  localparam int ntab = 32;
  localparam int njobs = 3;
  localparam int poll_limit = depth + 40;
  // each job cycle budget covers a few apb transfers per slot
  localparam int job_cycles = (depth + 40) * 12;
  localparam int limit_cycles = 10 + njobs * job_cycles;

  logic        clk;
  logic        rstn;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] tab_a [ntab];
  logic [31:0] tab_b [ntab];
  logic [31:0] tab_r [ntab];
  logic [31:0] seed;
  logic [31:0] rdval;
  int          value_errs;
  int          other_errs;

  fpv_top i_dut (
    .clk(clk), .rstn(rstn), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #2 clk = ~clk;

  initial begin
    #(limit_cycles * 4);
    $display("watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // normal range, product stays clear of overflow and underflow
  function automatic logic [31:0] rand_normal();
    logic [31:0] r;
    logic [31:0] m;
    r = lcg_next();
    m = lcg_next();
    return {r[31], 8'd100 + {2'b00, r[29:24]}, m[22:0]};
  endfunction

  function automatic logic [11:0] slot_addr(input logic [11:0] base, input int i);
    return base + 12'(4 * i);
  endfunction

  task automatic set_entry(input int i, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] r);
    tab_a[i] = a;
    tab_b[i] = b;
    tab_r[i] = r;
  endtask

  task automatic fill_table();
    // exact products
    set_entry(0, 32'h3fc00000, 32'h40000000, 32'h40400000);
    set_entry(1, 32'hc0400000, 32'h3f000000, 32'hbfc00000);
    set_entry(2, 32'h40800000, 32'h3e800000, 32'h3f800000);
    set_entry(3, 32'h3f800000, 32'h3f800000, 32'h3f800000);
    // signed zeros
    set_entry(4, 32'h80000000, 32'h40000000, 32'h80000000);
    set_entry(5, 32'h00000000, 32'hc0000000, 32'h80000000);
    set_entry(6, 32'h80000000, 32'h80000000, 32'h00000000);
    set_entry(7, 32'h3f800000, 32'h00000000, 32'h00000000);
    // subnormal input, min normal reached, deep underflow
    set_entry(8, 32'h00400000, 32'h3f800000, 32'h00400000);
    set_entry(9, 32'h1fffffff, 32'h20400000, 32'h00bfffff);
    set_entry(10, 32'h19000000, 32'h1e000000, 32'h00000020);
    set_entry(11, 32'h99000000, 32'h1e000000, 32'h80000020);
    // truncation, rounding would give 0x40100002
    set_entry(12, 32'h3fc00001, 32'h3fc00001, 32'h40100001);
    set_entry(13, 32'h3fffffff, 32'h3fffffff, 32'h407ffffe);
    for (int i = 14; i < ntab; i++) begin
      tab_a[i] = rand_normal();
      tab_b[i] = rand_normal();
      tab_r[i] = fmul_model(tab_a[i], tab_b[i]);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdat,
                          output logic [31:0] rdat, output logic err, output int waits);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdat;
    @(negedge clk);
    penable = 1'b1;
    waits = 0;
    // look mid cycle while the bus is settled
    #1;
    while (!pready) begin
      waits++;
      @(negedge clk);
      #1;
    end
    rdat = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] unused;
    logic        err;
    int          waits;
    apb_xfer(1'b1, addr, data, unused, err, waits);
    if (err !== exp_err) begin
      value_errs++;
      $display("Fail at %0t ns: write to %h slave error %b expected %b", $time, addr, err,
               exp_err);
    end
    if (waits != 0) begin
      value_errs++;
      $display("Fail at %0t ns: write to %h took %0d wait states expected 0", $time, addr,
               waits);
    end
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    int   waits;
    int   exp_waits;
    apb_xfer(1'b0, addr, 32'h0, data, err, waits);
    // result window reads wait one cycle on the RAM
    exp_waits = (addr >= win_r && addr < win_r + 12'(4 * depth)) ? 1 : 0;
    if (waits != exp_waits) begin
      value_errs++;
      $display("Fail at %0t ns: read of %h took %0d wait states expected %0d", $time, addr,
               waits, exp_waits);
    end
    if (err !== 1'b0) begin
      value_errs++;
      $display("Fail at %0t ns: read of %h slave error %b expected 0", $time, addr, err);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_job(input int first, input int n);
    for (int i = 0; i < n; i++) begin
      apb_write(slot_addr(win_a, i), tab_a[first + i], 1'b0);
      apb_write(slot_addr(win_b, i), tab_b[first + i], 1'b0);
    end
    apb_write(addr_len, 32'(n), 1'b0);
  endtask

  task automatic start_job();
    logic [31:0] st;
    apb_write(addr_ctrl, 32'h1, 1'b0);
    // busy without done while the job runs
    apb_read(addr_status, st);
    check_word("status right after start", st, 32'h1);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    st = '0;
    polls = 0;
    while (!st[1] && polls < poll_limit) begin
      apb_read(addr_status, st);
      polls++;
    end
    if (!st[1]) begin
      other_errs++;
      $display("status done was never set after %0d polls", polls);
    end else begin
      check_word("status at done", st, 32'h2);
    end
  endtask

  task automatic check_results(input int first, input int n);
    logic [31:0] v;
    for (int i = 0; i < n; i++) begin
      apb_read(slot_addr(win_r, i), v);
      check_word($sformatf("result slot %0d", i), v, tab_r[first + i]);
    end
  endtask

  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    seed = 32'h9c8f14d9;
    value_errs = 0;
    other_errs = 0;
    fill_table();
    repeat (10) @(negedge clk);
    rstn = 1'b1;

    apb_read(addr_status, rdval);
    check_word("status after reset", rdval, 32'h0);

    // full length job over the fixed cases
    load_job(0, depth);
    start_job();
    wait_done();
    check_results(0, depth);

    load_job(16, 1);
    start_job();
    wait_done();
    check_results(16, 1);

    // writes while busy must bounce
    load_job(17, 15);
    start_job();
    apb_write(addr_len, 32'd3, 1'b1);
    apb_write(slot_addr(win_a, 14), 32'h3f800000, 1'b1);
    apb_write(slot_addr(win_b, 14), 32'h3f800000, 1'b1);
    wait_done();
    check_results(17, 15);
    apb_read(addr_len, rdval);
    check_word("length after busy write", rdval, 32'd15);
    apb_read(slot_addr(win_a, 3), rdval);
    check_word("operand window read", rdval, 32'h0);

    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
